/* hw/rename_pkg.sv */
package rename_pkg;

    // ==============================
    // Rename group geometry
    // ==============================

    // Instructions renamed per cycle
    localparam int LANES     = 3;

    // Architectural register file and ROB sizes
    localparam int ARCH_REGS = 32;
    localparam int ROB_DEPTH = 32;

    // ==============================
    // Field widths
    // ==============================

    localparam int ARCH_W    = 5;
    localparam int ROB_W     = 5;

    // One extra bit selects register file or ROB slot
    localparam int PHYS_W    = ROB_W + 1;

    // Must hold ROB_DEPTH itself, hence one bit over ROB_W
    localparam int COUNT_W   = ROB_W + 1;

    // ==============================
    // Shared types
    // ==============================

    typedef logic [ARCH_W-1:0]  arch_reg_t;
    typedef logic [ROB_W-1:0]   rob_idx_t;

    // Bit 5 clear is register file, set is ROB slot, low bits are the index
    typedef logic [PHYS_W-1:0]  phys_tag_t;

    // One bit per rename lane, lane 0 is the oldest
    typedef logic [LANES-1:0]   lane_mask_t;

    typedef logic [COUNT_W-1:0] free_count_t;

endpackage

/* hw/rob_slot_allocator.sv */
`timescale 1ns/10ps

module rob_slot_allocator import rename_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // Requests from decode, one per lane
    input  lane_mask_t decode_valid_i,

    // Retirement from the ROB, contiguous from lane 0
    input  lane_mask_t commit_valid_i,
    input  logic       flush_i,

    // Allocation results
    output lane_mask_t grant_o,
    output phys_tag_t  alloc_tag_o [LANES],
    output rob_idx_t   commit_slot_o [LANES],
    output lane_mask_t ready_o
);

    // ==============================
    // Allocator state
    // ==============================

    // Next slot to hand out
    rob_idx_t    alloc_ptr;
    // Oldest slot still allocated
    rob_idx_t    commit_ptr;
    // Slots free at the start of this cycle
    free_count_t free_count;

    free_count_t grant_cnt;
    free_count_t commit_cnt;
    free_count_t next_count;

    // ==============================
    // In-order grant and slot tags
    // ==============================

    always_comb begin
        free_count_t req_seen;
        rob_idx_t    slot;

        req_seen  = '0;
        grant_cnt = '0;
        for (int i = 0; i < LANES; i++) begin
            // Granted while older requesters have not used up the free slots
            grant_o[i] = decode_valid_i[i] && (req_seen < free_count);

            // A granted lane sits after every older requester, all of them granted
            slot           = alloc_ptr + rob_idx_t'(req_seen);
            alloc_tag_o[i] = {1'b1, slot};

            if (grant_o[i]) begin
                grant_cnt = grant_cnt + free_count_t'(1);
            end
            if (decode_valid_i[i]) begin
                req_seen = req_seen + free_count_t'(1);
            end
        end
    end

    // ==============================
    // Commit slots
    // ==============================

    // Commits retire the oldest slots in order, so lane i takes commit_ptr + i
    always_comb begin
        commit_cnt = '0;
        for (int i = 0; i < LANES; i++) begin
            commit_slot_o[i] = commit_ptr + rob_idx_t'(i);
            if (commit_valid_i[i]) begin
                commit_cnt = commit_cnt + free_count_t'(1);
            end
        end
    end

    // Count after this cycle's grants and commits
    assign next_count = free_count - grant_cnt + commit_cnt;

    // Thermometer of how many lanes could be served
    always_comb begin
        if (free_count >= free_count_t'(3)) begin
            ready_o = 3'b111;
        end else if (free_count == free_count_t'(2)) begin
            ready_o = 3'b011;
        end else if (free_count == free_count_t'(1)) begin
            ready_o = 3'b001;
        end else begin
            ready_o = 3'b000;
        end
    end

    // ==============================
    // Pointer and count update
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            alloc_ptr  <= '0;
            commit_ptr <= '0;
            free_count <= free_count_t'(ROB_DEPTH);
        end else if (flush_i) begin
            // Flush empties the ROB, same-cycle grants and commits are dropped
            alloc_ptr  <= '0;
            commit_ptr <= '0;
            free_count <= free_count_t'(ROB_DEPTH);
        end else begin
            // Pointers wrap at ROB_DEPTH through the index width
            alloc_ptr  <= alloc_ptr + rob_idx_t'(grant_cnt);
            commit_ptr <= commit_ptr + rob_idx_t'(commit_cnt);
            free_count <= next_count;
        end
    end

endmodule

/* hw/rename_map_table.sv */
`timescale 1ns/10ps

module rename_map_table import rename_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush_i,

    // Lookup addresses from decode
    input  arch_reg_t  rs1_arch_i [LANES],
    input  arch_reg_t  rs2_arch_i [LANES],
    input  arch_reg_t  rd_arch_i [LANES],
    input  lane_mask_t rd_write_en_i,

    // Allocation results
    input  lane_mask_t grant_i,
    input  phys_tag_t  alloc_tag_i [LANES],

    // Retirement, oldest lane first
    input  lane_mask_t commit_valid_i,
    input  arch_reg_t  commit_arch_i [LANES],
    input  rob_idx_t   commit_slot_i [LANES],

    // Base tags from the stored table
    output phys_tag_t  rs1_base_o [LANES],
    output phys_tag_t  rs2_base_o [LANES],
    output phys_tag_t  rd_old_o [LANES]
);

    // ==============================
    // Table storage
    // ==============================

    // One tag per architectural register
    phys_tag_t map_q [ARCH_REGS];

    // Table after commits only
    phys_tag_t map_committed [ARCH_REGS];
    // Table after commits and renames
    phys_tag_t map_d [ARCH_REGS];

    // ==============================
    // Read ports
    // ==============================

    // Reads see the table as stored, same-group updates come from forwarding
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rs1_base_o[i] = map_q[rs1_arch_i[i]];
            rs2_base_o[i] = map_q[rs2_arch_i[i]];
            // Mapping displaced by this lane, released when it retires
            rd_old_o[i]   = map_q[rd_arch_i[i]];
        end
    end

    // ==============================
    // Commit restore
    // ==============================

    always_comb begin
        arch_reg_t reg_idx;

        map_committed = map_q;
        for (int i = 0; i < LANES; i++) begin
            reg_idx = commit_arch_i[i];
            // Only when the entry still names the retiring slot
            if (commit_valid_i[i] && (reg_idx != '0) &&
                (map_committed[reg_idx] == {1'b1, commit_slot_i[i]})) begin
                // Value now lives in the register file
                map_committed[reg_idx] = {1'b0, reg_idx};
            end
        end
    end

    // ==============================
    // Rename writes
    // ==============================

    // Applied on top of commits, in lane order so the youngest writer wins
    always_comb begin
        arch_reg_t reg_idx;

        map_d = map_committed;
        for (int i = 0; i < LANES; i++) begin
            reg_idx = rd_arch_i[i];
            // x0 stays on tag 0
            if (grant_i[i] && rd_write_en_i[i] && (reg_idx != '0)) begin
                map_d[reg_idx] = alloc_tag_i[i];
            end
        end
    end

    // ==============================
    // Table update
    // ==============================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            // Identity map, every register in the register file
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= {1'b0, arch_reg_t'(r)};
            end
        end else if (flush_i) begin
            // Flush overrides commits and renames of the same cycle
            for (int r = 0; r < ARCH_REGS; r++) begin
                map_q[r] <= {1'b0, arch_reg_t'(r)};
            end
        end else begin
            map_q <= map_d;
        end
    end

endmodule

/* hw/source_forward.sv */
`timescale 1ns/10ps

module source_forward import rename_pkg::*; (
    // Register numbers of the group
    input  arch_reg_t  rs1_arch_i [LANES],
    input  arch_reg_t  rs2_arch_i [LANES],
    input  arch_reg_t  rd_arch_i [LANES],
    input  lane_mask_t rd_write_en_i,

    // Allocation results of the group
    input  lane_mask_t grant_i,
    input  phys_tag_t  alloc_tag_i [LANES],

    // Tags from the stored table
    input  phys_tag_t  rs1_base_i [LANES],
    input  phys_tag_t  rs2_base_i [LANES],

    // Final source tags
    output phys_tag_t  rs1_phys_o [LANES],
    output phys_tag_t  rs2_phys_o [LANES]
);

    // ==============================
    // Producer lanes
    // ==============================

    // Lanes whose destination lands in the table this cycle
    lane_mask_t producer;

    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            producer[j] = grant_i[j] && rd_write_en_i[j] && (rd_arch_i[j] != '0);
        end
    end

    // ==============================
    // Source selection
    // ==============================

    // Lane 0 has no older lane and keeps the table value
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            rs1_phys_o[i] = rs1_base_i[i];
            rs2_phys_o[i] = rs2_base_i[i];

            // Scan older lanes from oldest to youngest
            // a later match overrides, leaving the youngest producer
            for (int j = 0; j < i; j++) begin
                if (producer[j] && (rd_arch_i[j] == rs1_arch_i[i])) begin
                    rs1_phys_o[i] = alloc_tag_i[j];
                end
                if (producer[j] && (rd_arch_i[j] == rs2_arch_i[i])) begin
                    rs2_phys_o[i] = alloc_tag_i[j];
                end
            end
        end
    end

endmodule

/* hw/register_rename.sv */
`timescale 1ns/10ps

module register_rename import rename_pkg::*; (
    input  logic       clk,
    input  logic       reset,

    // ==============================
    // Decode side
    // ==============================
    input  lane_mask_t decode_valid_i,
    input  lane_mask_t rd_write_en_i,
    input  arch_reg_t  rs1_arch_i [LANES],
    input  arch_reg_t  rs2_arch_i [LANES],
    input  arch_reg_t  rd_arch_i [LANES],

    // ==============================
    // ROB side
    // ==============================
    input  lane_mask_t commit_valid_i,
    input  arch_reg_t  commit_arch_i [LANES],
    input  logic       flush_i,

    // ==============================
    // Rename results
    // ==============================
    output phys_tag_t  rs1_phys_o [LANES],
    output phys_tag_t  rs2_phys_o [LANES],
    output phys_tag_t  rd_phys_o [LANES],
    output phys_tag_t  old_rd_phys_o [LANES],
    output lane_mask_t rename_valid_o,
    output lane_mask_t rename_ready_o
);

    // Allocator results
    lane_mask_t grant;
    phys_tag_t  alloc_tag [LANES];
    rob_idx_t   commit_slot [LANES];
    lane_mask_t ready;

    // Stored table lookups
    phys_tag_t  rs1_base [LANES];
    phys_tag_t  rs2_base [LANES];
    phys_tag_t  rd_old [LANES];

    // Slot allocation, grants and commit slot indexes
    rob_slot_allocator u_alloc (
        .clk            (clk),
        .reset          (reset),
        .decode_valid_i (decode_valid_i),
        .commit_valid_i (commit_valid_i),
        .flush_i        (flush_i),
        .grant_o        (grant),
        .alloc_tag_o    (alloc_tag),
        .commit_slot_o  (commit_slot),
        .ready_o        (ready)
    );

    // Architectural to physical map
    rename_map_table u_map (
        .clk            (clk),
        .reset          (reset),
        .flush_i        (flush_i),
        .rs1_arch_i     (rs1_arch_i),
        .rs2_arch_i     (rs2_arch_i),
        .rd_arch_i      (rd_arch_i),
        .rd_write_en_i  (rd_write_en_i),
        .grant_i        (grant),
        .alloc_tag_i    (alloc_tag),
        .commit_valid_i (commit_valid_i),
        .commit_arch_i  (commit_arch_i),
        .commit_slot_i  (commit_slot),
        .rs1_base_o     (rs1_base),
        .rs2_base_o     (rs2_base),
        .rd_old_o       (rd_old)
    );

    // Same-group dependencies bypass the table
    source_forward u_fwd (
        .rs1_arch_i     (rs1_arch_i),
        .rs2_arch_i     (rs2_arch_i),
        .rd_arch_i      (rd_arch_i),
        .rd_write_en_i  (rd_write_en_i),
        .grant_i        (grant),
        .alloc_tag_i    (alloc_tag),
        .rs1_base_i     (rs1_base),
        .rs2_base_i     (rs2_base),
        .rs1_phys_o     (rs1_phys_o),
        .rs2_phys_o     (rs2_phys_o)
    );

    // Destination and displaced tags, valid only on renamed lanes
    assign rd_phys_o      = alloc_tag;
    assign old_rd_phys_o  = rd_old;

    // A granted lane is a renamed lane
    assign rename_valid_o = grant;
    assign rename_ready_o = ready;

endmodule

/* verif/clock_gen.sv */
`timescale 1ns/10ps

// Free-running clock, 8 ns period
module clock_gen (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

endmodule

/* verif/rename_tests.svh */
// ==============================
// Stimulus helpers
// ==============================

// Full group, random registers, x0 never as destination
task automatic random_group();
    decode_valid = '1;
    rd_write_en  = '1;
    for (int i = 0; i < LANES; i++) begin
        rd_arch[i]  = arch_reg_t'($urandom_range(31, 1));
        rs1_arch[i] = arch_reg_t'($urandom_range(31, 0));
        rs2_arch[i] = arch_reg_t'($urandom_range(31, 0));
    end
endtask

task automatic flush_all(input string test);
    flush = 1'b1;
    cycle(test);
endtask

task automatic check_masks(input string test, input lane_mask_t ready, input lane_mask_t valid);
    check_outputs(test);
    check(test, "ready", ready, rename_ready);
    check(test, "valid", valid, rename_valid);
    advance();
endtask

// ==============================
// Directed tests
// ==============================

// Sweep all registers, the last lane wraps to x0
task automatic test_reset_state();
    for (int k = 0; k < 11; k++) begin
        for (int i = 0; i < LANES; i++) begin
            rs1_arch[i] = arch_reg_t'(3 * k + i);
            rs2_arch[i] = arch_reg_t'(31 - 3 * k - i);
        end
        check_outputs("reset_state");
        check("reset_state", "ready", 3'b111, rename_ready);
        check("reset_state", "valid", 3'b000, rename_valid);
        for (int i = 0; i < LANES; i++) begin
            check("reset_state", "rs1 identity", rs1_arch[i], rs1_phys[i]);
        end
        advance();
    end
endtask

task automatic test_rename_groups();
    flush_all("rename_groups");
    decode_valid = '1;
    rd_write_en  = '1;
    for (int i = 0; i < LANES; i++) begin
        rd_arch[i] = arch_reg_t'(5 + i);
    end
    check_outputs("rename_groups");
    for (int i = 0; i < LANES; i++) begin
        check("rename_groups", "first tags", 32 + i, rd_phys[i]);
    end
    advance();
    // Next cycle sees x5..x7 in the table
    decode_valid[0] = 1'b1;
    rd_write_en[0]  = 1'b1;
    rs1_arch[0]     = 5;
    rs2_arch[0]     = 6;
    rd_arch[0]      = 7;
    check_outputs("rename_groups");
    check("rename_groups", "rs1 x5", 32, rs1_phys[0]);
    check("rename_groups", "rs2 x6", 33, rs2_phys[0]);
    check("rename_groups", "old x7", 34, old_rd_phys[0]);
    advance();
    // 40 slots in total, allocation wraps past slot 31
    for (int k = 0; k < 12; k++) begin
        random_group();
        commit_oldest(3);
        cycle("rename_groups");
    end
endtask

task automatic test_forwarding();
    flush_all("forwarding");
    decode_valid = '1;
    rd_write_en  = '1;
    rd_arch[0]   = 10;
    rd_arch[1]   = 10;
    rd_arch[2]   = 11;
    rs1_arch[1]  = 10;
    rs1_arch[2]  = 10;
    rs2_arch[2]  = 11;
    check_outputs("forwarding");
    check("forwarding", "lane1 from lane0", 32, rs1_phys[1]);
    check("forwarding", "lane2 from lane1", 33, rs1_phys[2]);
    check("forwarding", "own rd not used", 11, rs2_phys[2]);
    advance();
    // x0 writer and a lane without write enable
    decode_valid = '1;
    rd_write_en  = 3'b001;
    rd_arch[1]   = 12;
    rs2_arch[2]  = 12;
    check_outputs("forwarding");
    check("forwarding", "x0 source", 0, rs1_phys[2]);
    check("forwarding", "non-writer", 12, rs2_phys[2]);
    advance();
endtask

task automatic test_commit();
    flush_all("commit");
    for (int k = 0; k < 2; k++) begin
        decode_valid[0] = 1'b1;
        rd_write_en[0]  = 1'b1;
        rd_arch[0]      = 3;
        cycle("commit");
    end
    // Slot 0 is stale, x3 already points at slot 1
    commit_oldest(1);
    rs1_arch[0] = 3;
    check_outputs("commit");
    check("commit", "x3 before stale commit", 33, rs1_phys[0]);
    advance();
    commit_oldest(1);
    rs1_arch[0] = 3;
    check_outputs("commit");
    check("commit", "stale commit kept x3", 33, rs1_phys[0]);
    advance();
    rs1_arch[0] = 3;
    check_outputs("commit");
    check("commit", "x3 back in register file", 3, rs1_phys[0]);
    check("commit", "count refilled", 32, uut.u_alloc.free_count);
    advance();
endtask

task automatic test_exhaustion();
    flush_all("exhaustion");
    for (int k = 0; k < 10; k++) begin
        random_group();
        cycle("exhaustion");
    end
    // Two slots left
    decode_valid[0] = 1'b1;
    check_masks("exhaustion", 3'b011, 3'b001);
    random_group();
    check_masks("exhaustion", 3'b001, 3'b001);
    random_group();
    check_masks("exhaustion", 3'b000, 3'b000);
    random_group();
    commit_oldest(2);
    check_masks("exhaustion", 3'b000, 3'b000);
    random_group();
    check_masks("exhaustion", 3'b011, 3'b011);
endtask

task automatic test_flush();
    // Two free slots, so the flush cycle carries grants and a commit
    commit_oldest(2);
    cycle("flush");
    random_group();
    commit_oldest(1);
    flush = 1'b1;
    cycle("flush");
    random_group();
    check_outputs("flush");
    check("flush", "ready", 3'b111, rename_ready);
    check("flush", "rs1 identity", rs1_arch[0], rs1_phys[0]);
    check("flush", "rs2 identity", rs2_arch[0], rs2_phys[0]);
    for (int i = 0; i < LANES; i++) begin
        check("flush", "restart tags", 32 + i, rd_phys[i]);
    end
    advance();
endtask

/* verif/rename_tb.sv */
`timescale 1ns/10ps

module rename_tb import rename_pkg::*; ();

    localparam logic [31:0] SEED = 32'h9fe2_59d3;
    // Tests run well under 100 cycles, large margin on top
    localparam int WATCHDOG_CYCLES = 2000;

    logic       clk;
    logic       reset;
    lane_mask_t decode_valid;
    lane_mask_t rd_write_en;
    arch_reg_t  rs1_arch [LANES];
    arch_reg_t  rs2_arch [LANES];
    arch_reg_t  rd_arch [LANES];
    lane_mask_t commit_valid;
    arch_reg_t  commit_arch [LANES];
    logic       flush;
    phys_tag_t  rs1_phys [LANES];
    phys_tag_t  rs2_phys [LANES];
    phys_tag_t  rd_phys [LANES];
    phys_tag_t  old_rd_phys [LANES];
    lane_mask_t rename_valid;
    lane_mask_t rename_ready;

    // ==============================
    // Reference model state
    // ==============================
    phys_tag_t  ref_map [ARCH_REGS];
    rob_idx_t   ref_alloc_ptr;
    rob_idx_t   ref_commit_ptr;
    int         ref_count;
    // Destination of each slot in flight, source of commit stimulus
    arch_reg_t  slot_arch [ROB_DEPTH];
    // Expected grants and tags of the current cycle
    lane_mask_t exp_grant;
    phys_tag_t  exp_tag [LANES];
    int         errors;
    int         checks;

    clock_gen u_clk (.clk_o(clk));

    register_rename uut (
        .clk            (clk),
        .reset          (reset),
        .decode_valid_i (decode_valid),
        .rd_write_en_i  (rd_write_en),
        .rs1_arch_i     (rs1_arch),
        .rs2_arch_i     (rs2_arch),
        .rd_arch_i      (rd_arch),
        .commit_valid_i (commit_valid),
        .commit_arch_i  (commit_arch),
        .flush_i        (flush),
        .rs1_phys_o     (rs1_phys),
        .rs2_phys_o     (rs2_phys),
        .rd_phys_o      (rd_phys),
        .old_rd_phys_o  (old_rd_phys),
        .rename_valid_o (rename_valid),
        .rename_ready_o (rename_ready)
    );

    task automatic check(input string test, input string what,
                         input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s %s: expected %0d actual %0d", test, what, expected, actual);
        end
    endtask

    task automatic idle();
        decode_valid = '0;
        rd_write_en  = '0;
        commit_valid = '0;
        flush        = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            rs1_arch[i]    = '0;
            rs2_arch[i]    = '0;
            rd_arch[i]     = '0;
            commit_arch[i] = '0;
        end
    endtask

    // Identity map, empty ROB
    task automatic reset_model();
        for (int r = 0; r < ARCH_REGS; r++) begin
            ref_map[r] = phys_tag_t'(r);
        end
        ref_alloc_ptr  = '0;
        ref_commit_ptr = '0;
        ref_count      = ROB_DEPTH;
    endtask

    // Lane lands a new mapping in the table
    function automatic logic writes_reg(input int lane);
        return exp_grant[lane] && rd_write_en[lane] && (rd_arch[lane] != '0);
    endfunction

    // Expected outputs of the driven group, compared after settling
    task automatic check_outputs(input string test);
        int         avail;
        rob_idx_t   next_slot;
        phys_tag_t  want1;
        phys_tag_t  want2;
        logic       found1;
        logic       found2;
        lane_mask_t want_ready;

        #2;
        avail     = ref_count;
        next_slot = ref_alloc_ptr;
        // First requesters take free slots one by one
        for (int i = 0; i < LANES; i++) begin
            exp_grant[i] = 1'b0;
            exp_tag[i]   = {1'b1, next_slot};
            if (decode_valid[i] && (avail > 0)) begin
                exp_grant[i] = 1'b1;
                next_slot++;
                avail--;
            end
        end
        want_ready = lane_mask_t'((1 << ((ref_count < LANES) ? ref_count : LANES)) - 1);
        check(test, "rename_valid", exp_grant, rename_valid);
        check(test, "rename_ready", want_ready, rename_ready);
        check(test, "free_count", ref_count, uut.u_alloc.free_count);
        for (int i = 0; i < LANES; i++) begin
            want1  = ref_map[rs1_arch[i]];
            want2  = ref_map[rs2_arch[i]];
            found1 = 1'b0;
            found2 = 1'b0;
            // Walk back from the nearest older lane, first hit is the youngest
            for (int j = i - 1; j >= 0; j--) begin
                if (writes_reg(j) && !found1 && (rd_arch[j] == rs1_arch[i])) begin
                    want1  = exp_tag[j];
                    found1 = 1'b1;
                end
                if (writes_reg(j) && !found2 && (rd_arch[j] == rs2_arch[i])) begin
                    want2  = exp_tag[j];
                    found2 = 1'b1;
                end
            end
            check(test, $sformatf("rs1_phys[%0d]", i), want1, rs1_phys[i]);
            check(test, $sformatf("rs2_phys[%0d]", i), want2, rs2_phys[i]);
            if (exp_grant[i]) begin
                check(test, $sformatf("rd_phys[%0d]", i), exp_tag[i], rd_phys[i]);
                check(test, $sformatf("old_rd_phys[%0d]", i), ref_map[rd_arch[i]],
                      old_rd_phys[i]);
            end
        end
    endtask

    // Clock edge, model update, then back to the falling edge
    task automatic advance();
        int       ncommit;
        int       ngrant;
        rob_idx_t slot;

        @(posedge clk);
        ncommit = 0;
        ngrant  = 0;
        if (flush) begin
            reset_model();
        end else begin
            // Commits retire the oldest slots, renames come after
            for (int i = 0; i < LANES; i++) begin
                if (commit_valid[i]) begin
                    slot = ref_commit_ptr + rob_idx_t'(ncommit);
                    if ((commit_arch[i] != '0) && (ref_map[commit_arch[i]] == {1'b1, slot})) begin
                        ref_map[commit_arch[i]] = {1'b0, commit_arch[i]};
                    end
                    ncommit++;
                end
            end
            for (int i = 0; i < LANES; i++) begin
                if (exp_grant[i]) begin
                    slot_arch[exp_tag[i][ROB_W-1:0]] = rd_write_en[i] ? rd_arch[i] : '0;
                    if (writes_reg(i)) begin
                        ref_map[rd_arch[i]] = exp_tag[i];
                    end
                    ngrant++;
                end
            end
            ref_alloc_ptr  = ref_alloc_ptr + rob_idx_t'(ngrant);
            ref_commit_ptr = ref_commit_ptr + rob_idx_t'(ncommit);
            ref_count      = ref_count - ngrant + ncommit;
        end
        @(negedge clk);
        idle();
    endtask

    task automatic cycle(input string test);
        check_outputs(test);
        advance();
    endtask

    // Retire up to n of the oldest slots in flight
    task automatic commit_oldest(input int n);
        int in_flight;

        in_flight = ROB_DEPTH - ref_count;
        for (int i = 0; (i < n) && (i < in_flight) && (i < LANES); i++) begin
            commit_valid[i] = 1'b1;
            commit_arch[i]  = slot_arch[ref_commit_ptr + rob_idx_t'(i)];
        end
    endtask

    `include "rename_tests.svh"

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        idle();
        reset = 1'b0;
        reset_model();
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;
        test_reset_state();
        test_rename_groups();
        test_forwarding();
        test_commit();
        test_exhaustion();
        test_flush();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+verif
hw/rename_pkg.sv
hw/rob_slot_allocator.sv
hw/rename_map_table.sv
hw/source_forward.sv
hw/register_rename.sv
verif/clock_gen.sv
verif/rename_tb.sv
